// File: aggr/aggr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module aggr_unit (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 aggr_req_i,
  input  gat_pkg::acc_t       aggr_value_i,
  input  gat_pkg::feat_addr_t aggr_addr_i,
  input  wire                 aggr_last_i,
  input  gat_pkg::feat_addr_t rd_addr_i,
  output logic                aggr_ack_o,
  output gat_pkg::acc_t       rd_data_o,
  output logic                wr_en_o,
  output gat_pkg::feat_addr_t wr_addr_o,
  output gat_pkg::acc_t       wr_data_o
);

  gat_pkg::acc_t mem_q [2**gat_pkg::FEAT_ADDR_W];

  logic                ack_q;
  logic                wr_en_q;
  gat_pkg::acc_t       sum_q;     // Running sum of the current node
  gat_pkg::feat_addr_t wr_addr_q;
  gat_pkg::acc_t       wr_data_q;
  gat_pkg::acc_t       rd_data_q;

  logic          start;
  gat_pkg::acc_t total;

  assign start = aggr_req_i && !ack_q;
  assign total = sum_q + aggr_value_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q   <= 1'b0;
      wr_en_q <= 1'b0;
      sum_q   <= '0;
    end else begin
      wr_en_q <= 1'b0;   // Write strobe lasts one cycle
      if (start) begin
        ack_q <= 1'b1;
        if (aggr_last_i) begin
          sum_q   <= '0;
          wr_en_q <= 1'b1;
        end else begin
          sum_q <= total;
        end
      end else if (ack_q && !aggr_req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Feature memory and write payload
  always_ff @(posedge clk) begin
    if (start && aggr_last_i) begin
      mem_q[aggr_addr_i] <= total;
      wr_addr_q          <= aggr_addr_i;
      wr_data_q          <= total;
    end
    rd_data_q <= mem_q[rd_addr_i];
  end

  assign aggr_ack_o = ack_q;
  assign rd_data_o  = rd_data_q;
  assign wr_en_o    = wr_en_q;
  assign wr_addr_o  = wr_addr_q;
  assign wr_data_o  = wr_data_q;

endmodule

`default_nettype wire

// File: common/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Sizes
  localparam int unsigned NUM_FEAT    = 4;
  localparam int unsigned FEAT_W      = 12;
  localparam int unsigned ACC_W       = 32;
  localparam int unsigned FEAT_ADDR_W = 6;   // 64 memory words
  localparam int unsigned WGT_IDX_W   = 2;
  localparam int unsigned FLAG_W      = 6;

  // One feature or weight element
  typedef logic [FEAT_W-1:0] feat_t;

  // Element 0 sits in the lowest bits
  typedef logic [NUM_FEAT-1:0][FEAT_W-1:0] feat_vec_t;

  // Products, sums and stored words wrap modulo 2**ACC_W
  typedef logic [ACC_W-1:0] acc_t;

  typedef logic [FEAT_ADDR_W-1:0] feat_addr_t;
  typedef logic [WGT_IDX_W-1:0]   wgt_idx_t;

  // Node address watched by the debug monitor
  localparam feat_addr_t WATCH_ADDR = 6'd10;

  typedef enum logic [2:0] {
    IDLE,
    DMVM_REQ,
    DMVM_REL,
    AGGR_REQ,
    AGGR_REL,
    HOST_ACK
  } seq_state_t;

endpackage

`default_nettype wire

// File: compile.f
common/gat_pkg.sv
hdl/stage_sequencer.sv
dmvm/dmvm_engine.sv
aggr/aggr_unit.sv
hdl/debug_monitor.sv
hdl/gat_layer_top.sv
testbench/tb_gat_layer.sv

// File: dmvm/dmvm_engine.sv
`timescale 1ns/1ns
`default_nettype none

module dmvm_engine (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 wgt_we_i,
  input  gat_pkg::wgt_idx_t   wgt_idx_i,
  input  gat_pkg::feat_t      wgt_data_i,
  input  wire                 dmvm_req_i,
  input  gat_pkg::feat_vec_t  dmvm_feat_i,
  output logic                dmvm_ack_o,
  output gat_pkg::acc_t       dmvm_result_o
);

  gat_pkg::feat_t wgt_q [gat_pkg::NUM_FEAT];

  logic                     busy_q;
  logic                     ack_q;
  logic [gat_pkg::WGT_IDX_W:0] step_q;   // Counts 0 to NUM_FEAT
  gat_pkg::acc_t            acc_q;

  gat_pkg::wgt_idx_t idx;
  gat_pkg::acc_t     prod;

  // Weight register file, written only between commands
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q[wgt_idx_i] <= wgt_data_i;
    end
  end

  assign idx  = step_q[gat_pkg::WGT_IDX_W-1:0];
  assign prod = gat_pkg::acc_t'(wgt_q[idx]) * gat_pkg::acc_t'(dmvm_feat_i[idx]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      step_q <= '0;
      acc_q  <= '0;
    end else begin
      if (busy_q) begin
        if (step_q < (gat_pkg::WGT_IDX_W+1)'(gat_pkg::NUM_FEAT)) begin
          acc_q  <= acc_q + prod;   // One MAC per cycle
          step_q <= step_q + 1'b1;
        end else begin
          busy_q <= 1'b0;
          ack_q  <= 1'b1;
        end
      end else if (ack_q) begin
        if (!dmvm_req_i) ack_q <= 1'b0;
      end else if (dmvm_req_i) begin
        // New request starts from a clean accumulator
        busy_q <= 1'b1;
        step_q <= '0;
        acc_q  <= '0;
      end
    end
  end

  assign dmvm_ack_o    = ack_q;
  assign dmvm_result_o = acc_q;

endmodule

`default_nettype wire

// File: hdl/debug_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module debug_monitor (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      cmd_req_i,
  input  wire                      cmd_ack_i,
  input  wire                      dmvm_req_i,
  input  wire                      dmvm_ack_i,
  input  wire                      aggr_req_i,
  input  wire                      aggr_ack_i,
  input  wire                      wr_en_i,
  input  gat_pkg::feat_addr_t      wr_addr_i,
  input  gat_pkg::acc_t            wr_data_i,
  output logic [gat_pkg::FLAG_W-1:0] debug_flags_o,
  output gat_pkg::acc_t            debug_count_o,
  output gat_pkg::acc_t            debug_capture_o
);

  logic [gat_pkg::FLAG_W-1:0] flags_q;
  logic [gat_pkg::FLAG_W-1:0] lines;
  logic                       cmd_ack_d;
  gat_pkg::acc_t              count_q;
  gat_pkg::acc_t              capture_q;

  // Bit order from high to low is cmd_req, cmd_ack, dmvm_req, dmvm_ack, aggr_req, aggr_ack
  assign lines = {cmd_req_i, cmd_ack_i, dmvm_req_i, dmvm_ack_i, aggr_req_i, aggr_ack_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q   <= '0;
      cmd_ack_d <= 1'b0;
      count_q   <= '0;
      capture_q <= '0;
    end else begin
      flags_q   <= flags_q | lines;   // Sticky until reset
      cmd_ack_d <= cmd_ack_i;
      if (cmd_ack_i && !cmd_ack_d) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en_i && wr_addr_i == gat_pkg::WATCH_ADDR) begin
        capture_q <= wr_data_i;
      end
    end
  end

  assign debug_flags_o   = flags_q;
  assign debug_count_o   = count_q;
  assign debug_capture_o = capture_q;

endmodule

`default_nettype wire

// File: hdl/gat_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

module gat_layer_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      cmd_req_i,
  input  gat_pkg::feat_vec_t       cmd_feat_i,
  input  gat_pkg::feat_addr_t      cmd_addr_i,
  input  wire                      cmd_last_i,
  input  wire                      wgt_we_i,
  input  gat_pkg::wgt_idx_t        wgt_idx_i,
  input  gat_pkg::feat_t           wgt_data_i,
  input  gat_pkg::feat_addr_t      rd_addr_i,
  output logic                     cmd_ack_o,
  output gat_pkg::acc_t            rd_data_o,
  output logic [gat_pkg::FLAG_W-1:0] debug_flags_o,
  output gat_pkg::acc_t            debug_count_o,
  output gat_pkg::acc_t            debug_capture_o
);

  // dmvm stage port
  logic                dmvm_req;
  gat_pkg::feat_vec_t  dmvm_feat;
  logic                dmvm_ack;
  gat_pkg::acc_t       dmvm_result;

  // aggr stage port
  logic                aggr_req;
  gat_pkg::acc_t       aggr_value;
  gat_pkg::feat_addr_t aggr_addr;
  logic                aggr_last;
  logic                aggr_ack;

  // Memory write tap for the monitor
  logic                wr_en;
  gat_pkg::feat_addr_t wr_addr;
  gat_pkg::acc_t       wr_data;

  stage_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_req_i     (cmd_req_i),
    .cmd_feat_i    (cmd_feat_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_last_i    (cmd_last_i),
    .dmvm_ack_i    (dmvm_ack),
    .dmvm_result_i (dmvm_result),
    .aggr_ack_i    (aggr_ack),
    .cmd_ack_o     (cmd_ack_o),
    .dmvm_req_o    (dmvm_req),
    .dmvm_feat_o   (dmvm_feat),
    .aggr_req_o    (aggr_req),
    .aggr_value_o  (aggr_value),
    .aggr_addr_o   (aggr_addr),
    .aggr_last_o   (aggr_last)
  );

  dmvm_engine u_dmvm (
    .clk           (clk),
    .rst_n         (rst_n),
    .wgt_we_i      (wgt_we_i),
    .wgt_idx_i     (wgt_idx_i),
    .wgt_data_i    (wgt_data_i),
    .dmvm_req_i    (dmvm_req),
    .dmvm_feat_i   (dmvm_feat),
    .dmvm_ack_o    (dmvm_ack),
    .dmvm_result_o (dmvm_result)
  );

  aggr_unit u_aggr (
    .clk          (clk),
    .rst_n        (rst_n),
    .aggr_req_i   (aggr_req),
    .aggr_value_i (aggr_value),
    .aggr_addr_i  (aggr_addr),
    .aggr_last_i  (aggr_last),
    .rd_addr_i    (rd_addr_i),
    .aggr_ack_o   (aggr_ack),
    .rd_data_o    (rd_data_o),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data)
  );

  debug_monitor u_dbg (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_req_i       (cmd_req_i),
    .cmd_ack_i       (cmd_ack_o),
    .dmvm_req_i      (dmvm_req),
    .dmvm_ack_i      (dmvm_ack),
    .aggr_req_i      (aggr_req),
    .aggr_ack_i      (aggr_ack),
    .wr_en_i         (wr_en),
    .wr_addr_i       (wr_addr),
    .wr_data_i       (wr_data),
    .debug_flags_o   (debug_flags_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

endmodule

`default_nettype wire

// File: hdl/stage_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stage_sequencer (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 cmd_req_i,
  input  gat_pkg::feat_vec_t  cmd_feat_i,
  input  gat_pkg::feat_addr_t cmd_addr_i,
  input  wire                 cmd_last_i,
  input  wire                 dmvm_ack_i,
  input  gat_pkg::acc_t       dmvm_result_i,
  input  wire                 aggr_ack_i,
  output logic                cmd_ack_o,
  output logic                dmvm_req_o,
  output gat_pkg::feat_vec_t  dmvm_feat_o,
  output logic                aggr_req_o,
  output gat_pkg::acc_t       aggr_value_o,
  output gat_pkg::feat_addr_t aggr_addr_o,
  output logic                aggr_last_o
);

  gat_pkg::seq_state_t state_q;

  gat_pkg::feat_vec_t  feat_q;
  gat_pkg::feat_addr_t addr_q;
  logic                last_q;
  gat_pkg::acc_t       value_q;   // Dot product kept for the aggr stage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= gat_pkg::IDLE;
    end else begin
      case (state_q)
        gat_pkg::IDLE:     if (cmd_req_i)   state_q <= gat_pkg::DMVM_REQ;
        gat_pkg::DMVM_REQ: if (dmvm_ack_i)  state_q <= gat_pkg::DMVM_REL;
        gat_pkg::DMVM_REL: if (!dmvm_ack_i) state_q <= gat_pkg::AGGR_REQ;
        gat_pkg::AGGR_REQ: if (aggr_ack_i)  state_q <= gat_pkg::AGGR_REL;
        gat_pkg::AGGR_REL: if (!aggr_ack_i) state_q <= gat_pkg::HOST_ACK;
        gat_pkg::HOST_ACK: if (!cmd_req_i)  state_q <= gat_pkg::IDLE;
        default:                            state_q <= gat_pkg::IDLE;
      endcase
    end
  end

  // Command is captured on the way out of IDLE
  always_ff @(posedge clk) begin
    if (state_q == gat_pkg::IDLE && cmd_req_i) begin
      feat_q <= cmd_feat_i;
      addr_q <= cmd_addr_i;
      last_q <= cmd_last_i;
    end
    if (state_q == gat_pkg::DMVM_REQ && dmvm_ack_i) begin
      value_q <= dmvm_result_i;   // Result is valid while ack is high
    end
  end

  assign dmvm_req_o = (state_q == gat_pkg::DMVM_REQ);
  assign aggr_req_o = (state_q == gat_pkg::AGGR_REQ);
  assign cmd_ack_o  = (state_q == gat_pkg::HOST_ACK);

  assign dmvm_feat_o  = feat_q;
  assign aggr_value_o = value_q;
  assign aggr_addr_o  = addr_q;
  assign aggr_last_o  = last_q;

endmodule

`default_nettype wire

// File: testbench/tb_gat_layer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gat_layer;

  localparam int NUM_SINGLE     = 16;
  localparam int NUM_GROUPS     = 12;
  localparam int MAX_CMDS       = NUM_SINGLE + NUM_GROUPS * gat_pkg::NUM_FEAT;
  localparam int TIMEOUT_CYCLES = MAX_CMDS * 40 + 2000;
  localparam int MEM_WORDS      = 2**gat_pkg::FEAT_ADDR_W;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_req_i;
  gat_pkg::feat_vec_t         cmd_feat_i;
  gat_pkg::feat_addr_t        cmd_addr_i;
  logic                       cmd_last_i;
  logic                       wgt_we_i;
  gat_pkg::wgt_idx_t          wgt_idx_i;
  gat_pkg::feat_t             wgt_data_i;
  gat_pkg::feat_addr_t        rd_addr_i;
  wire                        cmd_ack_o;
  gat_pkg::acc_t              rd_data_o;
  logic [gat_pkg::FLAG_W-1:0] debug_flags_o;
  gat_pkg::acc_t              debug_count_o;
  gat_pkg::acc_t              debug_capture_o;

  integer seed;
  int     errors;
  int     checks;
  int     cmds_sent;
  int     a;
  int     n;
  int     g;
  int     group_len;

  // Reference model state
  gat_pkg::feat_t      wgt_m [gat_pkg::NUM_FEAT];
  gat_pkg::acc_t       sum_m;
  gat_pkg::acc_t       mem_m [MEM_WORDS];
  logic                written_m [MEM_WORDS];
  gat_pkg::acc_t       watch_m;
  gat_pkg::feat_addr_t node;

  gat_layer_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_req_i       (cmd_req_i),
    .cmd_feat_i      (cmd_feat_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_last_i      (cmd_last_i),
    .wgt_we_i        (wgt_we_i),
    .wgt_idx_i       (wgt_idx_i),
    .wgt_data_i      (wgt_data_i),
    .rd_addr_i       (rd_addr_i),
    .cmd_ack_o       (cmd_ack_o),
    .rd_data_o       (rd_data_o),
    .debug_flags_o   (debug_flags_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic next_cycle;
    @(posedge clk);
    #1;   // Drive and sample just after the edge
  endtask

  task automatic compare(input string name, input gat_pkg::acc_t exp, input gat_pkg::acc_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic load_weights;
    int i;
    for (i = 0; i < gat_pkg::NUM_FEAT; i++) begin
      wgt_m[i]   = gat_pkg::feat_t'($random(seed));
      wgt_we_i   = 1'b1;
      wgt_idx_i  = gat_pkg::wgt_idx_t'(i);
      wgt_data_i = wgt_m[i];
      next_cycle();
    end
    wgt_we_i = 1'b0;
  endtask

  task automatic send_cmd(input gat_pkg::feat_addr_t addr, input logic last);
    gat_pkg::feat_vec_t feat;
    gat_pkg::acc_t      dot;
    int                 hold;
    int                 i;
    dot = '0;
    for (i = 0; i < gat_pkg::NUM_FEAT; i++) begin
      feat[i] = gat_pkg::feat_t'($random(seed));
      dot     = dot + gat_pkg::acc_t'(wgt_m[i]) * gat_pkg::acc_t'(feat[i]);
    end
    hold = $unsigned($random(seed)) % 4;   // Host back-pressure
    checks++;
    if (cmd_ack_o) begin
      errors++;
      $display("Handshake: cmd_ack_o was already high before the request rose");
    end
    cmd_feat_i = feat;
    cmd_addr_i = addr;
    cmd_last_i = last;
    cmd_req_i  = 1'b1;
    next_cycle();
    while (!cmd_ack_o) next_cycle();
    repeat (hold) next_cycle();
    checks++;
    if (!cmd_ack_o) begin
      errors++;
      $display("Handshake: cmd_ack_o dropped while the request was still high");
    end
    cmd_req_i = 1'b0;
    next_cycle();
    checks++;
    if (cmd_ack_o) begin
      errors++;
      $display("Handshake: cmd_ack_o still high one cycle after the request fell");
    end
    cmds_sent++;
    if (last) begin
      mem_m[addr]     = sum_m + dot;
      written_m[addr] = 1'b1;
      sum_m           = '0;
      if (addr == gat_pkg::WATCH_ADDR) watch_m = mem_m[addr];
    end else begin
      sum_m = sum_m + dot;
    end
  endtask

  task automatic read_check(input gat_pkg::feat_addr_t addr, input string name);
    rd_addr_i = addr;
    next_cycle();   // Read port has one cycle of latency
    compare(name, mem_m[addr], rd_data_o);
  endtask

  initial begin
    seed      = 49;
    errors    = 0;
    checks    = 0;
    cmds_sent = 0;
    sum_m     = '0;
    watch_m   = '0;
    for (a = 0; a < MEM_WORDS; a++) begin
      written_m[a] = 1'b0;
    end
    rst_n      = 1'b0;
    cmd_req_i  = 1'b0;
    cmd_feat_i = '0;
    cmd_addr_i = '0;
    cmd_last_i = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_idx_i  = '0;
    wgt_data_i = '0;
    rd_addr_i  = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    next_cycle();

    compare("reset_flags", '0, gat_pkg::acc_t'(debug_flags_o));
    compare("reset_count", '0, debug_count_o);
    compare("reset_capture", '0, debug_capture_o);
    compare("reset_ack", '0, gat_pkg::acc_t'(cmd_ack_o));

    // Each single command is a complete node
    load_weights();
    for (n = 0; n < NUM_SINGLE; n++) begin
      node = (n % 6 == 0) ? gat_pkg::WATCH_ADDR : gat_pkg::feat_addr_t'($random(seed));
      send_cmd(node, 1'b1);
      read_check(node, "dot_product");
    end

    // Groups of neighbors per node
    load_weights();
    for (g = 0; g < NUM_GROUPS; g++) begin
      node      = (g % 4 == 1) ? gat_pkg::WATCH_ADDR : gat_pkg::feat_addr_t'($random(seed));
      group_len = 1 + ($unsigned($random(seed)) % gat_pkg::NUM_FEAT);
      for (n = 0; n < group_len; n++) begin
        send_cmd(node, n == group_len - 1);
      end
      read_check(node, "aggregation");
    end

    // Earlier nodes must still hold their results
    for (a = 0; a < MEM_WORDS; a++) begin
      if (written_m[a]) read_check(gat_pkg::feat_addr_t'(a), "memory_retain");
    end

    compare("debug_flags", gat_pkg::acc_t'({gat_pkg::FLAG_W{1'b1}}),
            gat_pkg::acc_t'(debug_flags_o));
    compare("debug_count", gat_pkg::acc_t'(cmds_sent), debug_count_o);
    compare("debug_capture", watch_m, debug_capture_o);

    $display("Commands: %0d, checks: %0d, errors: %0d", cmds_sent, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
